// File: verilog/keccak_defs.svh
// keccak-f[1600] constants shared by the permutation datapath and controller
`ifndef KECCAK_DEFS_SVH
`define KECCAK_DEFS_SVH

// lane width in bits
`define KECCAK_W 64

// side of the 5x5 lane grid
`define KECCAK_N 5

// lanes in one state
`define KECCAK_LANES 25

// rounds per permutation
`define KECCAK_ROUNDS 24

// width of the iota round-constant lfsr
`define KECCAK_LFSR_W 8

`endif

// File: verilog/keccak_pkg.sv
// keccak-f[1600] types for lanes, grid coordinates, rounds and controller phases
`default_nettype none

`include "keccak_defs.svh"

package keccak_pkg;

	// one state lane
	typedef logic [`KECCAK_W-1:0] lane_t;

	// x or y position in the grid, 0 to 4
	typedef logic [2:0] coord_t;

	// round index, 0 to 23
	typedef logic [4:0] round_t;

	// controller phases
	// one round is theta_c, theta_rp, then five read/write pairs of chi rows
	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		THETA_C,
		THETA_RP,
		CHI_READ,
		CHI_WRITE,
		UNLOAD
	} phase_t;

endpackage

`default_nettype wire

// File: verilog/lane_ram.sv
// 25-lane state memory with a synchronous write port and a combinational read port
`default_nettype none

`include "keccak_defs.svh"

module lane_ram (
	input  logic               clk,
	input  logic               we,
	input  keccak_pkg::coord_t wx,
	input  keccak_pkg::coord_t wy,
	input  keccak_pkg::lane_t  wd,
	input  keccak_pkg::coord_t rx,
	input  keccak_pkg::coord_t ry,
	output keccak_pkg::lane_t  rd
);
	import keccak_pkg::*;

	lane_t      mem [`KECCAK_LANES];
	logic [4:0] widx;
	logic [4:0] ridx;

	// lane index is x fastest, then y
	assign widx = 5'(`KECCAK_N * wy + wx);
	assign ridx = 5'(`KECCAK_N * ry + rx);

	always_ff @(posedge clk) begin
		if (we)
			mem[widx] <= wd;
	end

	assign rd = mem[ridx];

endmodule

`default_nettype wire

// File: verilog/round_const.sv
// iota round-constant generator built on the 8-bit keccak lfsr
`default_nettype none

`include "keccak_defs.svh"

module round_const (
	input  logic              clk,
	input  logic              rst,
	input  logic              rc_init,
	input  logic              rc_step,
	output keccak_pkg::lane_t rc
);
	import keccak_pkg::*;

	// feedback flips bits 0, 4, 5 and 6 when the top bit shifts out
	localparam logic [`KECCAK_LFSR_W-1:0] lfsr_taps = 8'h71;

	logic [`KECCAK_LFSR_W-1:0] lfsr;
	logic [2:0]                step_cnt;
	logic [5:0]                bit_pos;
	logic                      busy;
	lane_t                     acc;

	// seven lfsr steps build one constant, count of 7 means done
	assign busy = (step_cnt != 3'd7);
	// bit positions 0, 1, 3, 7, 15, 31, 63
	assign bit_pos = 6'((1 << step_cnt) - 1);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lfsr <= `KECCAK_LFSR_W'(1);
			step_cnt <= 3'd7;
		end else if (rc_init) begin
			// restart the sequence at the round 0 seed
			lfsr <= `KECCAK_LFSR_W'(1);
			step_cnt <= 3'd0;
		end else if (rc_step) begin
			step_cnt <= 3'd0;
		end else if (busy) begin
			lfsr <= {lfsr[`KECCAK_LFSR_W-2:0], 1'b0} ^
				(lfsr[`KECCAK_LFSR_W-1] ? lfsr_taps : '0);
			step_cnt <= step_cnt + 3'd1;
		end
	end

	// next constant accumulates while the current one is in use
	always_ff @(posedge clk) begin
		if (rc_init || rc_step)
			acc <= '0;
		else if (busy)
			acc[bit_pos] <= lfsr[0];
		if (rc_step)
			rc <= acc;
	end

endmodule

`default_nettype wire

// File: verilog/theta_rho_pi.sv
// theta column parity and the per-lane theta, rho and pi transform
`default_nettype none

`include "keccak_defs.svh"

module theta_rho_pi (
	input  logic               clk,
	input  logic               rst,
	input  logic               acc_en,
	input  logic               xform_en,
	input  keccak_pkg::coord_t x,
	input  keccak_pkg::coord_t y,
	input  keccak_pkg::lane_t  a,
	output keccak_pkg::lane_t  b,
	output keccak_pkg::coord_t px,
	output keccak_pkg::coord_t py
);
	import keccak_pkg::*;

	// rho offsets indexed by 5*y+x
	localparam int unsigned rho_tab [`KECCAK_LANES] = '{
		0,  1,  62, 28, 27,
		36, 44, 6,  55, 20,
		3,  10, 43, 25, 39,
		41, 45, 15, 21, 8,
		18, 2,  61, 56, 14
	};

	lane_t      c [`KECCAK_N];
	coord_t     xm1;
	coord_t     xp1;
	logic [4:0] lane_idx;
	logic [5:0] rot_amt;
	lane_t      d;
	lane_t      t;

	function automatic lane_t rotl(input lane_t v, input int unsigned n);
		// shift by the full width yields zero, so n of 0 is safe
		return (v << n) | (v >> (`KECCAK_W - n));
	endfunction

	// column parity, first lane of a column loads instead of xor
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < `KECCAK_N; i++)
				c[i] <= '0;
		end else if (acc_en) begin
			if (y == 3'd0)
				c[x] <= a;
			else
				c[x] <= c[x] ^ a;
		end
	end

	// neighbour columns wrap around the grid
	assign xm1 = coord_t'((x + `KECCAK_N - 1) % `KECCAK_N);
	assign xp1 = coord_t'((x + 1) % `KECCAK_N);

	// theta column mix
	assign d = c[xm1] ^ rotl(c[xp1], 1);
	assign t = a ^ d;

	// rho rotation for this lane
	assign lane_idx = 5'(`KECCAK_N * y + x);
	assign rot_amt = 6'(rho_tab[lane_idx]);

	assign b = xform_en ? rotl(t, rot_amt) : '0;

	// pi moves lane (x,y) to (y, 2x+3y)
	assign px = y;
	assign py = coord_t'((2 * x + 3 * y) % `KECCAK_N);

endmodule

`default_nettype wire

// File: verilog/chi_row.sv
// five-lane row buffer computing chi, with iota folded into lane (0,0)
`default_nettype none

`include "keccak_defs.svh"

module chi_row (
	input  logic               clk,
	input  logic               load_en,
	input  keccak_pkg::coord_t col,
	input  keccak_pkg::lane_t  bin,
	input  keccak_pkg::lane_t  rc,
	input  logic               apply_rc,
	output keccak_pkg::lane_t  out
);
	import keccak_pkg::*;

	lane_t  row [`KECCAK_N];
	coord_t col_p1;
	coord_t col_p2;
	lane_t  chi;

	// one lane per cycle while the row is read from scratch
	always_ff @(posedge clk) begin
		if (load_en)
			row[col] <= bin;
	end

	// the two lanes to the right, wrapping at x=4
	assign col_p1 = coord_t'((col + 1) % `KECCAK_N);
	assign col_p2 = coord_t'((col + 2) % `KECCAK_N);

	// nonlinear step of the round
	assign chi = row[col] ^ (~row[col_p1] & row[col_p2]);

	// iota only on the first lane of row 0
	assign out = apply_rc ? (chi ^ rc) : chi;

endmodule

`default_nettype wire

// File: verilog/perm_ctrl.sv
// permutation phase FSM with lane and round counters and the I/O strobes
`default_nettype none

`include "keccak_defs.svh"

module perm_ctrl (
	input  logic               clk,
	input  logic               rst,
	input  logic               pushin,
	input  logic               firstin,
	input  logic               stopout,
	input  keccak_pkg::coord_t pi_x,
	input  keccak_pkg::coord_t pi_y,
	output logic               stopin,
	output logic               pushout,
	output logic               firstout,
	output logic               state_we,
	output logic               state_wsel,
	output keccak_pkg::coord_t state_wx,
	output keccak_pkg::coord_t state_wy,
	output keccak_pkg::coord_t state_rx,
	output keccak_pkg::coord_t state_ry,
	output logic               scratch_we,
	output keccak_pkg::coord_t scratch_wx,
	output keccak_pkg::coord_t scratch_wy,
	output keccak_pkg::coord_t scratch_rx,
	output keccak_pkg::coord_t scratch_ry,
	output logic               acc_en,
	output logic               xform_en,
	output logic               chi_load,
	output keccak_pkg::coord_t chi_col,
	output logic               apply_rc,
	output logic               rc_init,
	output logic               rc_step
);
	import keccak_pkg::*;

	phase_t phase;
	phase_t phase_nx;
	coord_t x;
	coord_t y;
	coord_t x_nx;
	coord_t y_nx;
	coord_t gx;
	coord_t gy;
	round_t round;
	round_t round_nx;
	logic   x_last;
	logic   y_last;
	logic   grid_last;
	logic   accept;

	assign x_last = (x == coord_t'(`KECCAK_N - 1));
	assign y_last = (y == coord_t'(`KECCAK_N - 1));
	assign grid_last = x_last && y_last;
	// input only taken while stopin is low
	assign accept = pushin && !stopin;

	// next grid position, x fastest
	assign gx = x_last ? 3'd0 : x + 3'd1;
	assign gy = x_last ? (y_last ? 3'd0 : y + 3'd1) : y;

	// all memory traffic follows the lane counters
	assign state_wx = x;
	assign state_wy = y;
	assign state_rx = x;
	assign state_ry = y;
	assign scratch_rx = x;
	assign scratch_ry = y;
	assign chi_col = x;
	// scratch writes land at the pi destination
	assign scratch_wx = pi_x;
	assign scratch_wy = pi_y;

	always_comb begin
		phase_nx = phase;
		x_nx = x;
		y_nx = y;
		round_nx = round;
		state_we = 1'b0;
		state_wsel = 1'b0;
		scratch_we = 1'b0;
		acc_en = 1'b0;
		xform_en = 1'b0;
		chi_load = 1'b0;
		apply_rc = 1'b0;
		rc_init = 1'b0;
		rc_step = 1'b0;
		pushout = 1'b0;
		firstout = 1'b0;
		case (phase)
			IDLE: begin
				rc_init = 1'b1;
				// lane 0 only with firstin, stray pushes dropped
				if (accept && firstin) begin
					state_we = 1'b1;
					x_nx = 3'd1;
					phase_nx = LOAD;
				end
			end
			LOAD: begin
				if (accept) begin
					state_we = 1'b1;
					x_nx = gx;
					y_nx = gy;
					if (grid_last)
						phase_nx = THETA_C;
				end
			end
			THETA_C: begin
				acc_en = 1'b1;
				x_nx = gx;
				y_nx = gy;
				if (grid_last)
					phase_nx = THETA_RP;
			end
			THETA_RP: begin
				xform_en = 1'b1;
				scratch_we = 1'b1;
				x_nx = gx;
				y_nx = gy;
				if (grid_last)
					phase_nx = CHI_READ;
			end
			CHI_READ: begin
				chi_load = 1'b1;
				// latch this round's constant just before row 0 is written
				rc_step = (y == 3'd0) && x_last;
				x_nx = gx;
				if (x_last)
					phase_nx = CHI_WRITE;
			end
			CHI_WRITE: begin
				state_we = 1'b1;
				state_wsel = 1'b1;
				apply_rc = (x == 3'd0) && (y == 3'd0);
				x_nx = gx;
				if (x_last) begin
					y_nx = gy;
					if (!y_last) begin
						phase_nx = CHI_READ;
					end else if (round == round_t'(`KECCAK_ROUNDS - 1)) begin
						round_nx = '0;
						phase_nx = UNLOAD;
					end else begin
						round_nx = round + 5'd1;
						phase_nx = THETA_C;
					end
				end
			end
			UNLOAD: begin
				pushout = !stopout;
				firstout = pushout && (x == 3'd0) && (y == 3'd0);
				// counters hold while the sink stalls
				if (pushout) begin
					x_nx = gx;
					y_nx = gy;
					if (grid_last)
						phase_nx = IDLE;
				end
			end
			default: begin
				phase_nx = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			phase <= IDLE;
			x <= '0;
			y <= '0;
			round <= '0;
			stopin <= 1'b1;
		end else begin
			phase <= phase_nx;
			x <= x_nx;
			y <= y_nx;
			round <= round_nx;
			// open for input only in idle and load
			stopin <= !(phase_nx == IDLE || phase_nx == LOAD);
		end
	end

endmodule

`default_nettype wire

// File: verilog/keccak_perm.sv
// keccak-f[1600] permutation top with a strobed lane interface on each side
`default_nettype none

module keccak_perm (
	input  logic              clk,
	input  logic              rst,
	input  logic              pushin,
	input  logic              firstin,
	input  keccak_pkg::lane_t din,
	output logic              stopin,
	output logic              pushout,
	output logic              firstout,
	output keccak_pkg::lane_t dout,
	input  logic              stopout
);
	import keccak_pkg::*;

	logic   state_we;
	logic   state_wsel;
	coord_t state_wx;
	coord_t state_wy;
	coord_t state_rx;
	coord_t state_ry;
	lane_t  state_wd;
	lane_t  state_rd;
	logic   scratch_we;
	coord_t scratch_wx;
	coord_t scratch_wy;
	coord_t scratch_rx;
	coord_t scratch_ry;
	lane_t  scratch_rd;
	logic   acc_en;
	logic   xform_en;
	logic   chi_load;
	coord_t chi_col;
	logic   apply_rc;
	logic   rc_init;
	logic   rc_step;
	lane_t  rc;
	lane_t  xform_lane;
	coord_t pi_x;
	coord_t pi_y;
	lane_t  chi_lane;

	perm_ctrl ctrl (
		.clk, .rst, .pushin, .firstin, .stopout, .pi_x, .pi_y,
		.stopin, .pushout, .firstout,
		.state_we, .state_wsel, .state_wx, .state_wy, .state_rx, .state_ry,
		.scratch_we, .scratch_wx, .scratch_wy, .scratch_rx, .scratch_ry,
		.acc_en, .xform_en, .chi_load, .chi_col, .apply_rc, .rc_init, .rc_step
	);

	// input lanes while loading, chi results during the rounds
	assign state_wd = state_wsel ? chi_lane : din;

	lane_ram state_ram (
		.clk, .we(state_we), .wx(state_wx), .wy(state_wy), .wd(state_wd),
		.rx(state_rx), .ry(state_ry), .rd(state_rd)
	);

	// holds the rho/pi output between theta and chi
	lane_ram scratch_ram (
		.clk, .we(scratch_we), .wx(scratch_wx), .wy(scratch_wy), .wd(xform_lane),
		.rx(scratch_rx), .ry(scratch_ry), .rd(scratch_rd)
	);

	theta_rho_pi trp (
		.clk, .rst, .acc_en, .xform_en, .x(state_rx), .y(state_ry),
		.a(state_rd), .b(xform_lane), .px(pi_x), .py(pi_y)
	);

	chi_row chi (
		.clk, .load_en(chi_load), .col(chi_col), .bin(scratch_rd),
		.rc, .apply_rc, .out(chi_lane)
	);

	round_const rcgen (
		.clk, .rst, .rc_init, .rc_step, .rc
	);

	// unload reads the state at the output lane counter
	assign dout = state_rd;

endmodule

`default_nettype wire

// File: bench/keccak_model.sv
// reference keccak-f[1600] functions that predict the permuted state for the testbench
`default_nettype none

`include "keccak_defs.svh"

package keccak_model;

	import keccak_pkg::*;

	// whole state, lane index 5*y+x
	typedef lane_t [`KECCAK_LANES-1:0] state_t;

	// lane 0 of keccak-f applied to the all-zero state
	localparam lane_t zero_lane0 = 64'hF125_8F79_40E1_DDE7;
	// cycles per block, permutation plus a slow load and a stalled unload
	localparam int block_cycle_limit = 4000;
	localparam int grid = `KECCAK_N;

	// rotate one bit at a time
	function automatic lane_t rotate_left(input lane_t v, input int n);
		lane_t r;
		r = v;
		for (int i = 0; i < n; i++)
			r = {r[`KECCAK_W-2:0], r[`KECCAK_W-1]};
		return r;
	endfunction

	// rc(t) from the 9-bit shift form of the standard
	function automatic logic rc_bit(input int t);
		logic [8:0] r;
		r = 9'd1;
		for (int i = 0; i < t % 255; i++) begin
			r = {r[7:0], 1'b0};
			r[0] = r[0] ^ r[8];
			r[4] = r[4] ^ r[8];
			r[5] = r[5] ^ r[8];
			r[6] = r[6] ^ r[8];
			r = {1'b0, r[7:0]};
		end
		return r[0];
	endfunction

	// bits land at 2^j - 1 for j from 0 to 6
	function automatic lane_t round_constant(input int ir);
		lane_t rc;
		rc = '0;
		for (int j = 0; j <= 6; j++)
			rc[(1 << j) - 1] = rc_bit(j + 7 * ir);
		return rc;
	endfunction

	// offsets follow the (t+1)(t+2)/2 walk starting at (1,0)
	function automatic int rho_offset(input int x, input int y);
		int cx;
		int cy;
		int nx;
		int off;
		cx = 1;
		cy = 0;
		off = 0;
		for (int t = 0; t < 24; t++) begin
			if (cx == x && cy == y)
				off = ((t + 1) * (t + 2) / 2) % `KECCAK_W;
			nx = cy;
			cy = (2 * cx + 3 * cy) % grid;
			cx = nx;
		end
		return off;
	endfunction

	function automatic state_t keccak_f(input state_t s_in);
		state_t s;
		lane_t  c [`KECCAK_N];
		lane_t  d [`KECCAK_N];
		lane_t  b [`KECCAK_LANES];
		s = s_in;
		for (int r = 0; r < `KECCAK_ROUNDS; r++) begin
			// theta
			for (int x = 0; x < grid; x++)
				c[x] = s[x] ^ s[x + 5] ^ s[x + 10] ^ s[x + 15] ^ s[x + 20];
			for (int x = 0; x < grid; x++)
				d[x] = c[(x + 4) % grid] ^ rotate_left(c[(x + 1) % grid], 1);
			for (int i = 0; i < `KECCAK_LANES; i++)
				s[i] = s[i] ^ d[i % grid];
			// rho then pi, (x,y) goes to (y, 2x+3y)
			for (int y = 0; y < grid; y++)
				for (int x = 0; x < grid; x++)
					b[grid * ((2 * x + 3 * y) % grid) + y] =
						rotate_left(s[grid * y + x], rho_offset(x, y));
			// chi along each row
			for (int y = 0; y < grid; y++)
				for (int x = 0; x < grid; x++)
					s[grid * y + x] = b[grid * y + x] ^
						(~b[grid * y + (x + 1) % grid] & b[grid * y + (x + 2) % grid]);
			// iota on lane (0,0)
			s[0] = s[0] ^ round_constant(r);
		end
		return s;
	endfunction

endpackage

`default_nettype wire

// File: bench/tb_keccak_perm.sv
// testbench for the keccak-f[1600] permutation with random lanes, input gaps and back-pressure
`default_nettype none

`include "keccak_defs.svh"

module tb_keccak_perm;
	timeunit 1ns;
	timeprecision 100ps;

	import keccak_pkg::*;
	import keccak_model::*;

	localparam int num_blocks = 20;
	localparam int reset_cycles = 8;
	// four passes over the lanes per round
	localparam int perm_cycles = `KECCAK_ROUNDS * 4 * `KECCAK_LANES;
	localparam int max_cycles = num_blocks * block_cycle_limit + reset_cycles;

	logic  clk;
	logic  rst;
	logic  pushin;
	logic  firstin;
	lane_t din;
	logic  stopin;
	logic  pushout;
	logic  firstout;
	lane_t dout;
	logic  stopout;
	int    seed;
	int    cycle_count = 0;

	keccak_perm DUT (
		.clk, .rst, .pushin, .firstin, .din, .stopin,
		.pushout, .firstout, .dout, .stopout
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// run is bounded by a budget per block
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > max_cycles) begin
			$display("Timeout: the run did not finish within %0d clock cycles", max_cycles);
			$display("RESULT: FAIL");
			$fatal(1, "simulation timed out");
		end
	end

	// true with probability 1/(mask+1)
	function automatic logic chance(input int mask);
		return (($random(seed) & mask) == 0);
	endfunction

	function automatic lane_t random_lane();
		return {$random(seed), $random(seed)};
	endfunction

	task automatic check_lane(input string what, input lane_t got, input lane_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "lane check failed");
		end
	endtask

	task automatic check_first(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: firstout on %s is %b, expected %b", $time, what, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "firstout check failed");
		end
	endtask

	task automatic check_strobe(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "strobe check failed");
		end
	endtask

	// drive point, a fixed delay after the rising edge
	task automatic next_edge();
		@(posedge clk);
		#10;
	endtask

	// pushin without firstin while idle must be dropped
	task automatic send_stray_pushes();
		int count;
		count = 1 + ($random(seed) & 3);
		for (int i = 0; i < count; i++) begin
			next_edge();
			pushin = 1'b1;
			firstin = 1'b0;
			din = random_lane();
			stopout = chance(1);
			@(negedge clk);
			check_strobe("stopin while idle", stopin, 1'b0);
			check_strobe("pushout while idle", pushout, 1'b0);
		end
	endtask

	// one lane per pushin, with random gaps
	task automatic send_block(input state_t blk);
		int   k;
		logic go;
		k = 0;
		while (k < `KECCAK_LANES) begin
			next_edge();
			go = !chance(3);
			pushin = go;
			firstin = go && (k == 0);
			din = go ? blk[k] : random_lane();
			stopout = chance(1);
			@(negedge clk);
			check_strobe("stopin while loading", stopin, 1'b0);
			check_strobe("pushout while loading", pushout, 1'b0);
			check_first("a load cycle", firstout, 1'b0);
			if (go)
				k++;
		end
	endtask

	// stray pushes keep coming while the block is busy
	task automatic receive_block(input state_t expected);
		int n;
		int busy;
		n = 0;
		busy = 0;
		while (n < `KECCAK_LANES) begin
			next_edge();
			pushin = chance(7);
			firstin = chance(1);
			din = random_lane();
			stopout = chance(3);
			@(negedge clk);
			check_strobe("stopin while busy", stopin, 1'b1);
			// unload starts right after the fixed-length permutation
			if (busy < perm_cycles)
				check_strobe("pushout during the permutation", pushout, 1'b0);
			else
				check_strobe("pushout while unloading", pushout, !stopout);
			// a transfer completes at the coming edge
			if (pushout) begin
				check_lane($sformatf("output lane %0d", n), dout, expected[n]);
				check_first($sformatf("transfer %0d", n), firstout, n == 0);
				n++;
			end else begin
				check_first("a cycle without transfer", firstout, 1'b0);
			end
			busy++;
		end
	endtask

	initial begin
		state_t blk;
		state_t expected;
		seed = 32'h050b_89c9;
		rst = 1'b1;
		pushin = 1'b0;
		firstin = 1'b0;
		din = '0;
		stopout = 1'b0;
		// pushes during reset and right after it have no effect
		for (int i = 0; i < reset_cycles; i++) begin
			next_edge();
			if (i == reset_cycles - 1)
				rst = 1'b0;
			pushin = chance(1);
			firstin = chance(1);
			din = random_lane();
			@(negedge clk);
			check_strobe("stopin after reset", stopin, 1'b1);
			check_strobe("pushout after reset", pushout, 1'b0);
			check_first("reset", firstout, 1'b0);
		end
		for (int b = 0; b < num_blocks; b++) begin
			// block 0 is the all-zero state
			if (b == 0) begin
				blk = '0;
			end else begin
				for (int i = 0; i < `KECCAK_LANES; i++)
					blk[i] = random_lane();
			end
			expected = keccak_f(blk);
			if (b == 0)
				check_lane("model lane 0 of the zero state", expected[0], zero_lane0);
			if (b % 5 == 2)
				send_stray_pushes();
			send_block(blk);
			receive_block(expected);
		end
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+verilog
verilog/keccak_pkg.sv
verilog/lane_ram.sv
verilog/round_const.sv
verilog/theta_rho_pi.sv
verilog/chi_row.sv
verilog/perm_ctrl.sv
verilog/keccak_perm.sv
bench/keccak_model.sv
bench/tb_keccak_perm.sv

// File: Makefile
# Verilator simulation of the keccak-f[1600] permutation
VERILATOR ?= verilator
TOP       ?= tb_keccak_perm
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --timescale $(TIMESCALE)

.PHONY: sim clean

# build and run, the exit status carries pass or fail
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
